/* common/dcache_defs.svh */
// cache geometry, bus widths and memory credit macros
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address split: tag | index | byte offset
`define DCACHE_ADDR_W      32
`define DCACHE_TAG_W       23
`define DCACHE_INDEX_W     6
`define DCACHE_OFFSET_W    3

// one 64-bit word per line
`define DCACHE_DATA_W      64
`define DCACHE_STRB_W      8

`define DCACHE_SETS        64

// saturating per-way age
`define DCACHE_AGE_W       3

// memory side flow control
`define DCACHE_MEM_CREDITS 2
`define DCACHE_CREDIT_W    2

`endif

/* common/dcache_pkg.sv */
// shared vector types and controller state encoding for the data cache
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0]   addr_t;
    typedef logic [`DCACHE_DATA_W-1:0]   data_t;
    typedef logic [`DCACHE_STRB_W-1:0]   strb_t;
    typedef logic [`DCACHE_TAG_W-1:0]    tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]  index_t;
    typedef logic [`DCACHE_AGE_W-1:0]    age_t;
    typedef logic [`DCACHE_CREDIT_W-1:0] credit_t;

    // one request in flight, misses loop back to lookup
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT
    } ctrl_state_t;

endpackage

/* dcache/dcache_ctrl.sv */
// request register, cache FSM, memory credit counter and array control
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                clk,
    input  logic                rst_n_i,
    // cpu side
    input  logic                cpu_valid_i,
    input  logic                cpu_write_i,
    input  dcache_pkg::addr_t   cpu_addr_i,
    input  dcache_pkg::data_t   cpu_wdata_i,
    input  dcache_pkg::strb_t   cpu_wstrb_i,
    output logic                cpu_ready_o,
    output logic                cpu_resp_valid_o,
    output dcache_pkg::data_t   cpu_rdata_o,
    // memory side
    output logic                mem_req_valid_o,
    output logic                mem_req_write_o,
    output dcache_pkg::addr_t   mem_req_addr_o,
    output dcache_pkg::data_t   mem_req_data_o,
    input  logic                mem_credit_i,
    input  logic                mem_rdata_valid_i,
    input  dcache_pkg::data_t   mem_rdata_i,
    // tag array
    input  logic                hit_i,
    input  logic                hit_way_i,
    input  logic                victim_way_i,
    input  logic                victim_dirty_i,
    input  dcache_pkg::tag_t    victim_tag_i,
    output dcache_pkg::index_t  index_o,
    output dcache_pkg::tag_t    tag_o,
    output logic                fill_en_o,
    output logic                fill_way_o,
    output logic                mark_dirty_en_o,
    output logic                mark_dirty_way_o,
    output logic                clean_en_o,
    // lru
    output logic                touch_en_o,
    output logic                touch_way_o,
    // data array
    input  dcache_pkg::data_t   rd_data_i,
    output logic                rd_way_o,
    output logic                wr_en_o,
    output logic                wr_way_o,
    output dcache_pkg::data_t   wr_data_o,
    output dcache_pkg::strb_t   wr_strb_o
);
    import dcache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    credit_t     credit_q;
    logic        have_credit;

    logic        req_write_q;
    tag_t        req_tag_q;
    index_t      req_index_q;
    data_t       req_wdata_q;
    strb_t       req_wstrb_q;

    assign cpu_ready_o      = (state_q == IDLE);
    assign cpu_resp_valid_o = (state_q == RESPOND);
    assign cpu_rdata_o      = rd_data_i;
    assign have_credit      = (credit_q != '0);

    always_ff @(posedge clk) begin
        if (cpu_valid_i && cpu_ready_o) begin
            req_write_q <= cpu_write_i;
            req_tag_q   <= cpu_addr_i[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
            req_index_q <= cpu_addr_i[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
            req_wdata_q <= cpu_wdata_i;
            req_wstrb_q <= cpu_wstrb_i;
        end
    end

    assign index_o = req_index_q;
    assign tag_o   = req_tag_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cpu_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_d = RESPOND;
                end else if (victim_dirty_i) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = FILL_REQ;
                end
            end
            RESPOND: state_d = IDLE;
            WRITEBACK: begin
                if (have_credit) begin
                    state_d = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (have_credit) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                // retry the lookup which now hits
                if (mem_rdata_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            credit_q <= credit_t'(`DCACHE_MEM_CREDITS);
        end else begin
            state_q  <= state_d;
            credit_q <= credit_q + credit_t'(mem_credit_i) - credit_t'(mem_req_valid_o);
        end
    end

    // memory requests held back while out of credits
    assign mem_req_valid_o = have_credit && (state_q == WRITEBACK || state_q == FILL_REQ);
    assign mem_req_write_o = (state_q == WRITEBACK);
    assign mem_req_addr_o  = (state_q == WRITEBACK) ?
                             {victim_tag_i, req_index_q, `DCACHE_OFFSET_W'(0)} :
                             {req_tag_q, req_index_q, `DCACHE_OFFSET_W'(0)};
    // victim word was read out during lookup
    assign mem_req_data_o  = rd_data_i;
    assign clean_en_o      = (state_q == WRITEBACK) && have_credit;

    // hit way while resident and victim way otherwise
    assign rd_way_o = hit_i ? hit_way_i : victim_way_i;

    assign fill_en_o        = (state_q == FILL_WAIT) && mem_rdata_valid_i;
    assign fill_way_o       = victim_way_i;
    assign mark_dirty_en_o  = (state_q == RESPOND) && req_write_q;
    assign mark_dirty_way_o = hit_way_i;
    assign touch_en_o       = (state_q == RESPOND);
    assign touch_way_o      = hit_way_i;

    assign wr_en_o   = mark_dirty_en_o || fill_en_o;
    assign wr_way_o  = (state_q == FILL_WAIT) ? victim_way_i : hit_way_i;
    assign wr_data_o = (state_q == FILL_WAIT) ? mem_rdata_i : req_wdata_q;
    assign wr_strb_o = (state_q == FILL_WAIT) ? '1 : req_wstrb_q;

    // out of credits nothing goes out until one returns
    assert property (@(posedge clk) disable iff (!rst_n_i)
        credit_q == '0 && !mem_credit_i |=> !mem_req_valid_o)
        else $error("memory request issued without a returned credit");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        credit_q <= credit_t'(`DCACHE_MEM_CREDITS))
        else $error("credit count %0d above initial value", credit_q);

    // fill data only expected while a fill is pending
    assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rdata_valid_i |-> state_q == FILL_WAIT)
        else $error("fill data outside FILL_WAIT, state %s", state_q.name());

endmodule

/* dcache/dcache_data_array.sv */
// two-way word storage, registered read, byte-masked write
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_data_array (
    input  logic               clk,
    input  dcache_pkg::index_t index_i,
    input  logic               rd_way_i,
    input  logic               wr_en_i,
    input  logic               wr_way_i,
    input  dcache_pkg::data_t  wr_data_i,
    input  dcache_pkg::strb_t  wr_strb_i,
    output dcache_pkg::data_t  rd_data_o
);
    import dcache_pkg::*;

    data_t mem_q [2][`DCACHE_SETS];

    // read data lands one edge after the index
    always_ff @(posedge clk) begin
        rd_data_o <= mem_q[rd_way_i][index_i];
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < `DCACHE_STRB_W; b++) begin
                if (wr_strb_i[b]) begin
                    mem_q[wr_way_i][index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

/* dcache/dcache_lru.sv */
// per-set saturating age counters and older-way select
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_lru (
    input  logic               clk,
    input  logic               rst_n_i,
    input  dcache_pkg::index_t index_i,
    input  logic               touch_en_i,
    input  logic               touch_way_i,
    output logic               older_way_o
);
    import dcache_pkg::*;

    age_t age_q [2][`DCACHE_SETS];
    logic other_way;

    assign other_way = !touch_way_i;

    // ties go to way 0
    assign older_way_o = (age_q[1][index_i] > age_q[0][index_i]);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                age_q[0][s] <= '0;
                age_q[1][s] <= '0;
            end
        end else if (touch_en_i) begin
            age_q[touch_way_i][index_i] <= '0;
            // saturate at all ones
            if (age_q[other_way][index_i] != '1) begin
                age_q[other_way][index_i] <= age_q[other_way][index_i] + age_t'(1);
            end
        end
    end

endmodule

/* dcache/dcache_tag_array.sv */
// valid, dirty and tag storage for two ways with hit and victim logic
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tag_array (
    input  logic               clk,
    input  logic               rst_n_i,
    input  dcache_pkg::index_t index_i,
    input  dcache_pkg::tag_t   tag_i,
    input  logic               older_way_i,
    input  logic               fill_en_i,
    input  logic               fill_way_i,
    input  logic               mark_dirty_en_i,
    input  logic               mark_dirty_way_i,
    input  logic               clean_en_i,
    output logic               hit_o,
    output logic               hit_way_o,
    output logic               victim_way_o,
    output logic               victim_dirty_o,
    output dcache_pkg::tag_t   victim_tag_o
);
    import dcache_pkg::*;

    logic [1:0] valid_q [`DCACHE_SETS];
    logic [1:0] dirty_q [`DCACHE_SETS];
    tag_t       tag_q   [2][`DCACHE_SETS];
    logic [1:0] way_hit;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[index_i][w] && (tag_q[w][index_i] == tag_i);
        end
        hit_o     = |way_hit;
        hit_way_o = way_hit[1];

        // fill empty ways first, way 0 before way 1
        if (!valid_q[index_i][0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[index_i][1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = older_way_i;
        end
        victim_dirty_o = dirty_q[index_i][victim_way_o];
        victim_tag_o   = tag_q[victim_way_o][index_i];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (fill_en_i) begin
                valid_q[index_i][fill_way_i] <= 1'b1;
                dirty_q[index_i][fill_way_i] <= 1'b0;
            end
            if (mark_dirty_en_i) begin
                dirty_q[index_i][mark_dirty_way_i] <= 1'b1;
            end
            // victim has just been written back
            if (clean_en_i) begin
                dirty_q[index_i][victim_way_o] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_q[fill_way_i][index_i] <= tag_i;
        end
    end

    // controller only fills after a miss, so a tag never lives in both ways
    assert property (@(posedge clk) disable iff (!rst_n_i) !(way_hit[0] && way_hit[1]))
        else $error("tag hit in both ways of set %0d", index_i);

endmodule

/* dcache/dcache_top.sv */
// data cache top level: controller, tag array, age counters, data array
`timescale 1ns/1ps

module dcache_top (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              cpu_valid_i,
    input  logic              cpu_write_i,
    input  dcache_pkg::addr_t cpu_addr_i,
    input  dcache_pkg::data_t cpu_wdata_i,
    input  dcache_pkg::strb_t cpu_wstrb_i,
    output logic              cpu_ready_o,
    output logic              cpu_resp_valid_o,
    output dcache_pkg::data_t cpu_rdata_o,
    output logic              mem_req_valid_o,
    output logic              mem_req_write_o,
    output dcache_pkg::addr_t mem_req_addr_o,
    output dcache_pkg::data_t mem_req_data_o,
    input  logic              mem_credit_i,
    input  logic              mem_rdata_valid_i,
    input  dcache_pkg::data_t mem_rdata_i
);
    import dcache_pkg::*;

    index_t index;
    tag_t   req_tag;
    tag_t   victim_tag;
    data_t  rd_data;
    data_t  wr_data;
    strb_t  wr_strb;
    logic   hit;
    logic   hit_way;
    logic   victim_way;
    logic   victim_dirty;
    logic   older_way;
    logic   fill_en;
    logic   fill_way;
    logic   mark_dirty_en;
    logic   mark_dirty_way;
    logic   clean_en;
    logic   touch_en;
    logic   touch_way;
    logic   rd_way;
    logic   wr_en;
    logic   wr_way;

    dcache_ctrl ctrl_i (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .cpu_valid_i       (cpu_valid_i),
        .cpu_write_i       (cpu_write_i),
        .cpu_addr_i        (cpu_addr_i),
        .cpu_wdata_i       (cpu_wdata_i),
        .cpu_wstrb_i       (cpu_wstrb_i),
        .cpu_ready_o       (cpu_ready_o),
        .cpu_resp_valid_o  (cpu_resp_valid_o),
        .cpu_rdata_o       (cpu_rdata_o),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_write_o   (mem_req_write_o),
        .mem_req_addr_o    (mem_req_addr_o),
        .mem_req_data_o    (mem_req_data_o),
        .mem_credit_i      (mem_credit_i),
        .mem_rdata_valid_i (mem_rdata_valid_i),
        .mem_rdata_i       (mem_rdata_i),
        .hit_i             (hit),
        .hit_way_i         (hit_way),
        .victim_way_i      (victim_way),
        .victim_dirty_i    (victim_dirty),
        .victim_tag_i      (victim_tag),
        .index_o           (index),
        .tag_o             (req_tag),
        .fill_en_o         (fill_en),
        .fill_way_o        (fill_way),
        .mark_dirty_en_o   (mark_dirty_en),
        .mark_dirty_way_o  (mark_dirty_way),
        .clean_en_o        (clean_en),
        .touch_en_o        (touch_en),
        .touch_way_o       (touch_way),
        .rd_data_i         (rd_data),
        .rd_way_o          (rd_way),
        .wr_en_o           (wr_en),
        .wr_way_o          (wr_way),
        .wr_data_o         (wr_data),
        .wr_strb_o         (wr_strb)
    );

    dcache_tag_array tag_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .index_i          (index),
        .tag_i            (req_tag),
        .older_way_i      (older_way),
        .fill_en_i        (fill_en),
        .fill_way_i       (fill_way),
        .mark_dirty_en_i  (mark_dirty_en),
        .mark_dirty_way_i (mark_dirty_way),
        .clean_en_i       (clean_en),
        .hit_o            (hit),
        .hit_way_o        (hit_way),
        .victim_way_o     (victim_way),
        .victim_dirty_o   (victim_dirty),
        .victim_tag_o     (victim_tag)
    );

    dcache_lru lru_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .index_i     (index),
        .touch_en_i  (touch_en),
        .touch_way_i (touch_way),
        .older_way_o (older_way)
    );

    dcache_data_array data_i (
        .clk       (clk),
        .index_i   (index),
        .rd_way_i  (rd_way),
        .wr_en_i   (wr_en),
        .wr_way_i  (wr_way),
        .wr_data_i (wr_data),
        .wr_strb_i (wr_strb),
        .rd_data_o (rd_data)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the data cache simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module dcache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vdcache_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* sim.f */
+incdir+common
common/dcache_pkg.sv
dcache/dcache_tag_array.sv
dcache/dcache_lru.sv
dcache/dcache_data_array.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

/* verif/dcache_mem_model.sv */
// backing memory model with credit return, fill delay and writeback storage
`timescale 1ns/1ps

module dcache_mem_model (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              hold_credit_i,
    input  logic              mem_req_valid_i,
    input  logic              mem_req_write_i,
    input  dcache_pkg::addr_t mem_req_addr_i,
    input  dcache_pkg::data_t mem_req_data_i,
    output logic              mem_credit_o,
    output logic              mem_rdata_valid_o,
    output dcache_pkg::data_t mem_rdata_o
);
    import dcache_pkg::*;

    data_t store [addr_t];
    logic  fill_busy;
    addr_t fill_addr;
    int    delay_q;
    int    fill_count;
    int    credits_owed;

    // untouched words hold their own address in both halves
    function automatic data_t read_word(input addr_t a);
        addr_t w;
        w = {a[31:3], 3'b000};
        if (store.exists(w)) begin
            return store[w];
        end
        return {w, w};
    endfunction

    always @(posedge clk) begin : model
        int owed;
        owed = credits_owed;
        if (!rst_n_i) begin
            fill_busy         <= 1'b0;
            delay_q           <= 0;
            fill_count        <= 0;
            credits_owed      <= 0;
            mem_credit_o      <= 1'b0;
            mem_rdata_valid_o <= 1'b0;
            mem_rdata_o       <= '0;
        end else begin
            mem_rdata_valid_o <= 1'b0;
            mem_credit_o      <= 1'b0;
            if (mem_req_valid_i && mem_req_write_i) begin
                store[{mem_req_addr_i[31:3], 3'b000}] = mem_req_data_i;
                owed = owed + 1;
            end else if (mem_req_valid_i) begin
                fill_busy  <= 1'b1;
                fill_addr  <= mem_req_addr_i;
                // fill latency cycles through 1 to 4
                delay_q    <= 1 + (fill_count % 4);
                fill_count <= fill_count + 1;
            end
            if (fill_busy) begin
                if (delay_q == 0) begin
                    mem_rdata_valid_o <= 1'b1;
                    mem_rdata_o       <= read_word(fill_addr);
                    fill_busy         <= 1'b0;
                    owed = owed + 1;
                end else begin
                    delay_q <= delay_q - 1;
                end
            end
            if (!hold_credit_i && owed > 0) begin
                mem_credit_o <= 1'b1;
                owed = owed - 1;
            end
            credits_owed <= owed;
        end
    end

endmodule

/* verif/dcache_tb.sv */
// data cache testbench with stimulus, shadow memory, assertions and reporting
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int TIMEOUT = 200;

    logic  clk;
    logic  rst_n;
    logic  cpu_valid_i, cpu_write_i, cpu_ready_o, cpu_resp_valid_o;
    addr_t cpu_addr_i;
    data_t cpu_wdata_i, cpu_rdata_o;
    strb_t cpu_wstrb_i;
    logic  mem_req_valid, mem_req_write, mem_credit, mem_rdata_valid, hold_credit;
    addr_t mem_req_addr;
    data_t mem_req_data, mem_rdata;

    data_t       shadow [addr_t];
    logic [15:0] lfsr;
    int          errors, tests, since_accept, outstanding, fill_total, wb_total;
    int          fill_base, wb_base, exp_fills, exp_wbs;
    logic        timed_out, expect_hit, mem_quiet, rd_check, wb_expected;
    logic        end_check;
    data_t       exp_rdata, exp_wb_data;
    addr_t       exp_wb_addr, exp_fill_addr;

    dcache_top dut_i (
        .clk(clk), .rst_n_i(rst_n),
        .cpu_valid_i(cpu_valid_i), .cpu_write_i(cpu_write_i), .cpu_addr_i(cpu_addr_i),
        .cpu_wdata_i(cpu_wdata_i), .cpu_wstrb_i(cpu_wstrb_i), .cpu_ready_o(cpu_ready_o),
        .cpu_resp_valid_o(cpu_resp_valid_o), .cpu_rdata_o(cpu_rdata_o),
        .mem_req_valid_o(mem_req_valid), .mem_req_write_o(mem_req_write),
        .mem_req_addr_o(mem_req_addr), .mem_req_data_o(mem_req_data),
        .mem_credit_i(mem_credit), .mem_rdata_valid_i(mem_rdata_valid), .mem_rdata_i(mem_rdata)
    );

    dcache_mem_model mem_i (
        .clk(clk), .rst_n_i(rst_n), .hold_credit_i(hold_credit),
        .mem_req_valid_i(mem_req_valid), .mem_req_write_i(mem_req_write),
        .mem_req_addr_i(mem_req_addr), .mem_req_data_i(mem_req_data),
        .mem_credit_o(mem_credit), .mem_rdata_valid_o(mem_rdata_valid), .mem_rdata_o(mem_rdata)
    );

    always #5 clk = ~clk;

    // bookkeeping sampled like flops
    always @(posedge clk) begin
        if (cpu_valid_i && cpu_ready_o) begin
            since_accept <= 1;
        end else begin
            since_accept <= since_accept + 1;
        end
        outstanding <= outstanding + int'(mem_req_valid) - int'(mem_credit);
        fill_total  <= fill_total + int'(mem_req_valid && !mem_req_write);
        wb_total    <= wb_total + int'(mem_req_valid && mem_req_write);
    end

    task automatic log_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    assert property (@(posedge clk) $rose(rst_n) |->
        cpu_ready_o && !mem_req_valid && !cpu_resp_valid_o)
        else log_error("reset state wrong: ready low or a valid high");
    assert property (@(posedge clk) disable iff (!rst_n)
        cpu_resp_valid_o && rd_check |-> cpu_rdata_o == exp_rdata)
        else log_error($sformatf("MISMATCH cpu_rdata_o exp %h got %h",
                                 exp_rdata, $sampled(cpu_rdata_o)));
    assert property (@(posedge clk) disable iff (!rst_n)
        cpu_resp_valid_o && expect_hit |-> since_accept == 2)
        else log_error($sformatf("MISMATCH cpu_resp_valid_o latency exp %h got %h",
                                 2, $sampled(since_accept)));
    assert property (@(posedge clk) disable iff (!rst_n) mem_quiet |-> !mem_req_valid)
        else log_error("memory request issued where none was expected");
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && mem_req_write |-> wb_expected)
        else log_error("unexpected writeback request");
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && mem_req_write && wb_expected |-> mem_req_addr == exp_wb_addr)
        else log_error($sformatf("MISMATCH mem_req_addr_o exp %h got %h",
                                 exp_wb_addr, $sampled(mem_req_addr)));
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && mem_req_write && wb_expected |-> mem_req_data == exp_wb_data)
        else log_error($sformatf("MISMATCH mem_req_data_o exp %h got %h",
                                 exp_wb_data, $sampled(mem_req_data)));
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_write |-> mem_req_addr == exp_fill_addr)
        else log_error($sformatf("MISMATCH mem_req_addr_o exp %h got %h",
                                 exp_fill_addr, $sampled(mem_req_addr)));
    assert property (@(posedge clk) disable iff (!rst_n)
        outstanding == `DCACHE_MEM_CREDITS |-> !mem_req_valid)
        else log_error("memory request issued with all credits outstanding");
    assert property (@(posedge clk) disable iff (!rst_n)
        end_check |-> fill_total - fill_base == exp_fills)
        else log_error($sformatf("MISMATCH mem_req_valid_o fill count exp %h got %h",
                                 exp_fills, $sampled(fill_total) - fill_base));
    assert property (@(posedge clk) disable iff (!rst_n)
        end_check |-> wb_total - wb_base == exp_wbs)
        else log_error($sformatf("MISMATCH mem_req_valid_o writeback count exp %h got %h",
                                 exp_wbs, $sampled(wb_total) - wb_base));

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic addr_t make_addr(input int tag, input int index);
        return {tag[22:0], index[5:0], 3'b000};
    endfunction

    function automatic data_t shadow_read(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return {a, a};
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic issue_req(input logic wr, input addr_t a, input data_t d, input strb_t s);
        int waited;
        waited = 0;
        if (timed_out) return;
        @(posedge clk);
        cpu_valid_i <= 1'b1;
        cpu_write_i <= wr;
        cpu_addr_i  <= a;
        cpu_wdata_i <= d;
        cpu_wstrb_i <= s;
        @(negedge clk);
        while (!cpu_ready_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!cpu_ready_o) report_timeout("cache never accepted the request");
        @(posedge clk);
        cpu_valid_i <= 1'b0;
    endtask

    task automatic wait_resp();
        int waited;
        waited = 0;
        if (timed_out) return;
        @(negedge clk);
        while (!cpu_resp_valid_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!cpu_resp_valid_o) report_timeout("no response from the cache");
        @(negedge clk);
    endtask

    task automatic access(input logic wr, input addr_t a, input logic hit);
        data_t d;
        strb_t s;
        d = take_bits(64);
        s = strb_t'(take_bits(8));
        expect_hit = hit;
        mem_quiet  = hit;
        rd_check   = !wr;
        exp_rdata  = shadow_read(a);
        exp_fill_addr = a;
        issue_req(wr, a, d, s);
        wait_resp();
        if (wr) begin
            for (int b = 0; b < 8; b++) begin
                if (s[b]) exp_rdata[b*8 +: 8] = d[b*8 +: 8];
            end
            shadow[a] = exp_rdata;
        end
    endtask

    task automatic expect_traffic(input int fills, input int wbs);
        fill_base = fill_total;
        wb_base   = wb_total;
        exp_fills = fills;
        exp_wbs   = wbs;
    endtask

    task automatic finish_test(input string name);
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        tests++;
        $display("test %s done, errors so far %0d", name, errors);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cpu_valid_i = 1'b0;
        cpu_write_i = 1'b0;
        cpu_addr_i = '0;
        cpu_wdata_i = '0;
        cpu_wstrb_i = '0;
        hold_credit = 1'b0;
        lfsr = 16'd20;
        errors = 0;
        tests = 0;
        since_accept = 0;
        outstanding = 0;
        fill_total = 0;
        wb_total = 0;
        timed_out = 1'b0;
        expect_hit = 1'b0;
        mem_quiet = 1'b0;
        rd_check = 1'b0;
        wb_expected = 1'b0;
        end_check = 1'b0;
        exp_rdata = '0;
        exp_wb_data = '0;
        exp_wb_addr = '0;
        exp_fill_addr = '0;
        expect_traffic(0, 0);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        @(negedge clk);
        finish_test("reset");

        expect_traffic(1, 0);
        access(1'b0, make_addr(5, 3), 1'b0);
        access(1'b0, make_addr(5, 3), 1'b1);
        finish_test("read_miss_hit");

        expect_traffic(0, 0);
        access(1'b1, make_addr(5, 3), 1'b1);
        access(1'b0, make_addr(5, 3), 1'b1);
        finish_test("write_merge");

        // A and B share set 9 and B ends up older
        expect_traffic(4, 2);
        access(1'b1, make_addr(17, 9), 1'b0);
        access(1'b1, make_addr(34, 9), 1'b0);
        access(1'b0, make_addr(17, 9), 1'b1);
        access(1'b0, make_addr(34, 9), 1'b1);
        access(1'b0, make_addr(17, 9), 1'b1);
        wb_expected = 1'b1;
        exp_wb_addr = make_addr(34, 9);
        exp_wb_data = shadow_read(exp_wb_addr);
        access(1'b0, make_addr(51, 9), 1'b0);
        // A is older now and goes back to memory
        exp_wb_addr = make_addr(17, 9);
        exp_wb_data = shadow_read(exp_wb_addr);
        access(1'b0, make_addr(34, 9), 1'b0);
        wb_expected = 1'b0;
        finish_test("dirty_evict");

        expect_traffic(3, 0);
        hold_credit = 1'b1;
        access(1'b0, make_addr(7, 20), 1'b0);
        access(1'b0, make_addr(7, 21), 1'b0);
        expect_hit = 1'b0;
        mem_quiet = 1'b0;
        rd_check = 1'b1;
        exp_rdata = shadow_read(make_addr(7, 22));
        exp_fill_addr = make_addr(7, 22);
        issue_req(1'b0, make_addr(7, 22), '0, '0);
        repeat (20) @(negedge clk);
        hold_credit = 1'b0;
        wait_resp();
        finish_test("credit_limit");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
